/* src/apu_pkg.sv */
package apu_pkg;

	typedef logic [15:0]	opcode_t;		// one code word
	typedef logic [7:0]		gpr_t;			// register value and alu width
	typedef logic [3:0]		gpr_idx_t;
	typedef logic [5:0]		border_t;		// low bits of the source reg

	localparam opcode_t OP_HALT = 16'hFFFF;	// also what the core sees while stopped

	// instruction class sits in opcode[15:12]
	typedef enum logic [3:0] {
		CLS_ALU_I_LAST	= 4'h7,		// 0..7 are alu with imm
		CLS_ALU_RR		= 4'h8,
		CLS_OUT			= 4'h9,
		CLS_JR			= 4'hA,
		CLS_WAIT		= 4'hB,
		CLS_HALT		= 4'hF
	} op_class_e;

	// same coding for imm and reg forms
	typedef enum logic [2:0] {
		ALU_LD,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_ADD,
		ALU_SUB,
		ALU_CMP,		// sub without write back
		ALU_TST			// and without write back
	} alu_func_e;

	// jr condition in opcode[11:8]
	typedef enum logic [3:0] {
		JC_ALWAYS	= 4'h0,
		JC_Z		= 4'h1,
		JC_C		= 4'h2,
		JC_NZ		= 4'h3,
		JC_NC_NZ	= 4'h4,		// unsigned greater
		JC_C_OR_Z	= 4'h5,		// unsigned less or equal
		JC_NC		= 4'h6,
		JC_N		= 4'h7,
		JC_NN		= 4'h8
	} jr_cond_e;

	// wait pin select, 6 and 7 read as zero
	typedef enum logic [2:0] {
		PIN_ONE,
		PIN_HSYNC_START,
		PIN_HBLANK,
		PIN_VSYNC,
		PIN_VBLANK,
		PIN_LINE_START
	} wait_pin_e;

	typedef enum logic [3:0] {
		PORT_BORDER	= 4'h0,
		PORT_COVOX	= 4'h1
	} out_port_e;

	typedef enum logic {
		ST_RUN,
		ST_HALTED
	} fetch_state_e;

	typedef struct packed {
		logic z;
		logic c;		// carry or borrow
		logic n;
	} flags_t;

	// video timing strobes and levels
	typedef struct packed {
		logic hsync_start;
		logic line_start;
		logic hblank;
		logic vsync;
		logic vblank;
	} video_pins_t;

	typedef struct packed {
		logic		en;
		gpr_idx_t	idx;
		gpr_t		data;
	} gpr_wr_t;

endpackage

/* src/apu_fetch.sv */
`timescale 1ns/1ps

module apu_fetch
	import apu_pkg::*;
#(
	parameter int CODE_AW = 8				// word address width of code ram
)
(
	input  logic				clk,
	input  logic				rst_n,
	input  logic				apu_halt,		// host stop
	input  logic				code_wen,
	input  logic [CODE_AW:0]	code_waddr,		// byte address
	input  logic [7:0]			code_wdata,
	input  video_pins_t			pins,
	input  flags_t				flags,
	output opcode_t				opcode,
	output logic				rdy
);

	localparam int CODE_WORDS = 2 ** CODE_AW;

	logic [7:0]			lo_byte;				// even byte waits for its odd partner
	opcode_t			code_mem [CODE_WORDS];
	opcode_t			code_q;					// sync ram output
	logic				armed;					// host has stopped the core at least once

	logic [CODE_AW-1:0]	pc;						// address of the presented word
	logic [CODE_AW-1:0]	pc_next;
	logic [CODE_AW-1:0]	pc_inc;
	logic [CODE_AW-1:0]	pc_rel;
	logic [CODE_AW-1:0]	rel;

	op_class_e			cls;
	jr_cond_e			jcond;
	wait_pin_e			wpin;
	logic				jr_take;
	logic				pin_sel;
	logic				pin_ok;
	logic				is_halt;
	fetch_state_e		state;

	// low byte latch
	always_ff @(posedge clk)
	begin
		if (code_wen && !code_waddr[0])
			lo_byte <= code_wdata;
	end

	// odd byte completes the word
	always_ff @(posedge clk)
	begin
		if (code_wen && code_waddr[0])
			code_mem[code_waddr[CODE_AW:1]] <= {code_wdata, lo_byte};
		code_q <= code_mem[pc_next];			// one cycle read latency
	end

	// ram content is unknown until the host has loaded it under apu_halt
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			armed <= 1'b0;
		else if (apu_halt)
			armed <= 1'b1;
	end

	assign opcode = (apu_halt || !armed) ? OP_HALT : code_q;

	// only the flow control classes matter here
	assign cls     = op_class_e'(opcode[15:12]);
	assign jcond   = jr_cond_e'(opcode[11:8]);
	assign wpin    = wait_pin_e'(opcode[2:0]);
	assign is_halt = (cls == CLS_HALT);

	assign rel    = CODE_AW'($signed(opcode[7:0]));	// sign extend, wraps in code space
	assign pc_inc = pc + 1'b1;
	assign pc_rel = pc + rel;

	always_comb
	begin
		case (jcond)
			JC_ALWAYS:	jr_take = 1'b1;
			JC_Z:		jr_take = flags.z;
			JC_C:		jr_take = flags.c;
			JC_NZ:		jr_take = !flags.z;
			JC_NC_NZ:	jr_take = !flags.c && !flags.z;
			JC_C_OR_Z:	jr_take = flags.c || flags.z;
			JC_NC:		jr_take = !flags.c;
			JC_N:		jr_take = flags.n;
			JC_NN:		jr_take = !flags.n;
			default:	jr_take = 1'b0;		// never
		endcase
	end

	always_comb
	begin
		case (wpin)
			PIN_ONE:			pin_sel = 1'b1;
			PIN_HSYNC_START:	pin_sel = pins.hsync_start;
			PIN_HBLANK:			pin_sel = pins.hblank;
			PIN_VSYNC:			pin_sel = pins.vsync;
			PIN_VBLANK:			pin_sel = pins.vblank;
			PIN_LINE_START:		pin_sel = pins.line_start;
			default:			pin_sel = 1'b0;
		endcase
	end

	assign pin_ok = pin_sel ^ opcode[11];		// bit 11 inverts

	always_comb
	begin
		if (apu_halt)
			pc_next = '0;
		else
		begin
			case (cls)
				CLS_HALT:	pc_next = pc;
				CLS_WAIT:	pc_next = pin_ok ? pc_inc : pc;		// spin on the same word
				CLS_JR:		pc_next = jr_take ? pc_rel : pc_inc;
				default:	pc_next = pc_inc;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc <= '0;
		else
			pc <= pc_next;
	end

	// rdy follows the presented word by one cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ST_RUN;
		else
			state <= is_halt ? ST_HALTED : ST_RUN;
	end

	assign rdy = (state == ST_HALTED);

	// host must stop the core before touching code ram
	a_load_halted: assert property (@(posedge clk) disable iff (!rst_n)
		code_wen |-> apu_halt)
		else $error("code write while the core runs");

endmodule

/* src/apu_gpr.sv */
`timescale 1ns/1ps

module apu_gpr
	import apu_pkg::*;
(
	input  logic		clk,
	input  gpr_idx_t	rd_a,			// destination operand
	input  gpr_idx_t	rd_b,			// source operand
	input  gpr_wr_t		wr,
	output gpr_t		q_a,
	output gpr_t		q_b
);

	gpr_t regs [16];

	// one write port, lands at the end of the exec cycle
	always_ff @(posedge clk)
	begin
		if (wr.en)
			regs[wr.idx] <= wr.data;
	end

	// async reads so exec sees operands in the same cycle
	assign q_a = regs[rd_a];
	assign q_b = regs[rd_b];

	// decode in exec must hand over a clean index with every write
	a_wr_idx_known: assert property (@(posedge clk)
		wr.en |-> !$isunknown(wr.idx))
		else $error("register write with unknown index");

endmodule

/* src/apu_exec.sv */
`timescale 1ns/1ps

module apu_exec
	import apu_pkg::*;
(
	input  logic		clk,
	input  logic		rst_n,
	input  opcode_t		opcode,
	input  gpr_t		q_a,
	input  gpr_t		q_b,
	output gpr_idx_t	rd_a,
	output gpr_idx_t	rd_b,
	output gpr_wr_t		wr,
	output flags_t		flags,
	output border_t		border,
	output logic		border_we,
	output gpr_t		covox,
	output logic		covox_we
);

	op_class_e	cls;
	alu_func_e	func;
	out_port_e	port;
	logic		is_alu_i;
	logic		is_alu_rr;
	logic		is_alu;
	logic		is_out;
	logic		out_border;
	logic		out_covox;
	gpr_t		op_b;				// imm or source reg
	gpr_t		res;
	logic		c_res;
	logic		wb_en;				// result goes back to dst
	logic		flag_en;

	assign cls       = op_class_e'(opcode[15:12]);
	assign is_alu_i  = (cls <= CLS_ALU_I_LAST);
	assign is_alu_rr = (cls == CLS_ALU_RR);
	assign is_alu    = is_alu_i || is_alu_rr;
	assign is_out    = (cls == CLS_OUT);

	// imm form keeps func in the class bits
	assign func = is_alu_rr ? alu_func_e'(opcode[6:4]) : alu_func_e'(opcode[14:12]);
	assign port = out_port_e'(opcode[7:4]);

	// read ports wired straight from the fields
	assign rd_a = opcode[11:8];		// dst
	assign rd_b = opcode[3:0];		// src for rr and out

	assign op_b = is_alu_rr ? q_b : opcode[7:0];

	always_comb
	begin
		res     = op_b;
		c_res   = 1'b0;				// logic ops clear carry
		wb_en   = 1'b1;
		flag_en = 1'b1;
		case (func)
			ALU_LD:
			begin
				flag_en = 1'b0;		// plain move
			end
			ALU_AND:	res = q_a & op_b;
			ALU_OR:		res = q_a | op_b;
			ALU_XOR:	res = q_a ^ op_b;
			ALU_ADD:	{c_res, res} = {1'b0, q_a} + {1'b0, op_b};
			ALU_SUB:	{c_res, res} = {1'b0, q_a} - {1'b0, op_b};	// bit 8 is borrow
			ALU_CMP:
			begin
				{c_res, res} = {1'b0, q_a} - {1'b0, op_b};
				wb_en = 1'b0;
			end
			ALU_TST:
			begin
				res   = q_a & op_b;
				wb_en = 1'b0;
			end
		endcase
	end

	assign wr = '{en: is_alu && wb_en, idx: opcode[11:8], data: res};

	// next instruction sees the new flags
	always_ff @(posedge clk)
	begin
		if (is_alu && flag_en)
		begin
			flags.z <= (res == '0);
			flags.c <= c_res;
			flags.n <= res[7];
		end
	end

	// out decode, unknown port numbers are dropped
	assign out_border = is_out && (port == PORT_BORDER);
	assign out_covox  = is_out && (port == PORT_COVOX);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border_we <= 1'b0;
			covox_we  <= 1'b0;
		end
		else
		begin
			border_we <= out_border;		// one pulse per out
			covox_we  <= out_covox;
		end
	end

	// port data holds between writes
	always_ff @(posedge clk)
	begin
		if (out_border)
			border <= q_b[5:0];
		if (out_covox)
			covox <= q_b;
	end

	// a single out feeds one port per cycle
	a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
		!(border_we && covox_we))
		else $error("border and covox strobes together");

endmodule

/* src/apu_top.sv */
`timescale 1ns/1ps

module apu_top
	import apu_pkg::*;
#(
	parameter int CODE_AW = 8				// 256 code words
)
(
	input  logic				clk,
	input  logic				rst_n,
	input  logic				apu_halt,
	input  logic				code_wen,
	input  logic [CODE_AW:0]	code_waddr,
	input  logic [7:0]			code_wdata,
	input  video_pins_t			pins,
	output logic				rdy,
	output border_t				border,
	output logic				border_we,
	output gpr_t				covox,
	output logic				covox_we
);

	opcode_t	opcode;
	flags_t		flags;
	gpr_idx_t	rd_a;
	gpr_idx_t	rd_b;
	gpr_t		q_a;
	gpr_t		q_b;
	gpr_wr_t	wr;

	// code ram and pc
	apu_fetch #(
		.CODE_AW	(CODE_AW)
	) u_fetch (
		.clk		(clk),
		.rst_n		(rst_n),
		.apu_halt	(apu_halt),
		.code_wen	(code_wen),
		.code_waddr	(code_waddr),
		.code_wdata	(code_wdata),
		.pins		(pins),
		.flags		(flags),
		.opcode		(opcode),
		.rdy		(rdy)
	);

	apu_gpr u_gpr (
		.clk	(clk),
		.rd_a	(rd_a),
		.rd_b	(rd_b),
		.wr		(wr),
		.q_a	(q_a),
		.q_b	(q_b)
	);

	// alu, flags and output ports
	apu_exec u_exec (
		.clk		(clk),
		.rst_n		(rst_n),
		.opcode		(opcode),
		.q_a		(q_a),
		.q_b		(q_b),
		.rd_a		(rd_a),
		.rd_b		(rd_b),
		.wr			(wr),
		.flags		(flags),
		.border		(border),
		.border_we	(border_we),
		.covox		(covox),
		.covox_we	(covox_we)
	);

endmodule

/* sim/apu_tb.sv */
`timescale 1ns/1ps

module apu_tb
	import apu_pkg::*;
();

	localparam int CODE_AW = 8;
	localparam int N_TESTS = 6;
	localparam int TIMEOUT = 200;			// cycles allowed per wait loop

	// programs of 16 words padded with halt
	localparam opcode_t PROG [N_TESTS][16] = '{
		'{16'h015A, 16'h9011, 16'h110F, 16'h9011, 16'h21C0, 16'h9011, 16'h31FF, 16'h9011,
		  16'h41E0, 16'h9011, 16'h5120, 16'h9011, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF},
		'{16'h0230, 16'h0325, 16'h8243, 16'h9002, 16'h0410, 16'h8453, 16'h9004, 16'hFFFF,
		  16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF},
		'{16'h0540, 16'h0711, 16'h0822, 16'h6540, 16'hA102, 16'h9018, 16'h9017, 16'h6550,
		  16'hA602, 16'h9018, 16'hA202, 16'h9017, 16'h6530, 16'hA502, 16'h9015, 16'hFFFF},
		'{16'h0103, 16'h9011, 16'h5101, 16'hA3FE, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF,
		  16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF},
		'{16'h0215, 16'hB003, 16'h9002, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF,
		  16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF},
		'{16'h0321, 16'h4321, 16'h9013, 16'h1321, 16'h9013, 16'h2321, 16'h7300, 16'h9013,
		  16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF, 16'hFFFF}
	};

	// expected writes as {covox, value}
	// border entries hold the full alu result
	localparam logic [8:0] EXP [N_TESTS][8] = '{
		'{9'h15A, 9'h10A, 9'h1CA, 9'h135, 9'h115, 9'h1F5, 9'h000, 9'h000},	// 5a, and, or, xor, add, sub
		'{9'h055, 9'h0EB, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000},	// 30+25, 10-25
		'{9'h111, 9'h122, 9'h140, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000},	// taken path only
		'{9'h103, 9'h102, 9'h101, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000},	// count down
		'{9'h015, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000},
		'{9'h142, 9'h100, 9'h121, 9'h000, 9'h000, 9'h000, 9'h000, 9'h000}	// tst leaves r3
	};
	localparam int NEXP [N_TESTS] = '{6, 2, 3, 3, 1, 3};
	localparam bit PULSE [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};	// vsync pulse

	string t_name [N_TESTS] = '{"alu_imm", "alu_rr_border", "jr_cond", "jr_loop",
		"wait_vsync", "byte_pairs"};

	logic				clk;
	logic				rst_n;
	logic				apu_halt;
	logic				code_wen;
	logic [CODE_AW:0]	code_waddr;
	logic [7:0]			code_wdata;
	video_pins_t		pins;
	logic				rdy;
	border_t			border;
	logic				border_we;
	gpr_t				covox;
	logic				covox_we;

	int				cyc;					// cycles since apu_halt fell
	int				pulse_at;
	bit				pulse_seen;
	int				n_seen;					// port writes so far in this test
	int				n_checks;
	int				value_errs;
	int				other_errs;

	apu_top #(
		.CODE_AW	(CODE_AW)
	) DUT (
		.clk		(clk),
		.rst_n		(rst_n),
		.apu_halt	(apu_halt),
		.code_wen	(code_wen),
		.code_waddr	(code_waddr),
		.code_wdata	(code_wdata),
		.pins		(pins),
		.rdy		(rdy),
		.border		(border),
		.border_we	(border_we),
		.covox		(covox),
		.covox_we	(covox_we)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_border(input string name, input border_t exp, input border_t act);
		n_checks++;
		if (act !== exp)
		begin
			$display("FAIL %s: border expected %02h actual %02h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_covox(input string name, input gpr_t exp, input gpr_t act);
		n_checks++;
		if (act !== exp)
		begin
			$display("FAIL %s: covox expected %02h actual %02h", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic check_rdy(input string name, input bit exp, input logic act);
		n_checks++;
		if (act !== exp)
		begin
			$display("FAIL %s: rdy expected %0b actual %0b", name, exp, act);
			value_errs++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		other_errs++;
	endtask

	// match one strobe against the next expected write
	task automatic take_write(input int t);
		string		nm;
		logic [8:0]	exp;
		nm = t_name[t];
		if (border_we && PULSE[t] && !pulse_seen)
			note_failure($sformatf("%s: border write before the vsync pulse", nm));
		if (n_seen >= NEXP[t])
			note_failure($sformatf("%s: extra port write beyond the %0d expected", nm, NEXP[t]));
		else
		begin
			exp = EXP[t][n_seen];
			if (exp[8])
			begin
				if (covox_we)
					check_covox(nm, exp[7:0], covox);
				else
					note_failure($sformatf("%s: border written where covox was due", nm));
			end
			else
			begin
				if (border_we)
					check_border(nm, exp[5:0], border);	// port keeps the low 6 bits
				else
					note_failure($sformatf("%s: covox written where border was due", nm));
			end
		end
		n_seen++;
	endtask

	// drive after the edge and sample strobes on the falling edge
	task automatic run_cycle(input int t);
		@(posedge clk);
		#1;
		pins.vsync = PULSE[t] && (cyc == pulse_at);
		if (pins.vsync)
			pulse_seen = 1'b1;
		cyc++;
		@(negedge clk);
		if (border_we || covox_we)
			take_write(t);
	endtask

	task automatic load_program(input int t);
		int w;
		@(posedge clk);
		#1;
		pins     = '0;
		apu_halt = 1'b1;					// code ram only writable while stopped
		@(posedge clk);
		#1;
		code_wen = 1'b1;
		for (w = 0; w < 16; w++)
		begin
			code_waddr = {w[CODE_AW-1:0], 1'b0};	// low byte first
			code_wdata = PROG[t][w][7:0];
			@(posedge clk);
			#1;
			code_waddr[0] = 1'b1;				// odd byte writes the word
			code_wdata    = PROG[t][w][15:8];
			@(posedge clk);
			#1;
		end
		code_wen = 1'b0;
		repeat (2)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_program(input int t);
		int cnt;
		cyc        = 0;
		pulse_seen = 1'b0;
		n_seen     = 0;
		if (PULSE[t])
			pulse_at = 4 + int'($urandom % 12);	// idle cycles before vsync
		apu_halt = 1'b0;
		cnt = 0;
		while (rdy !== 1'b0 && cnt < TIMEOUT)
		begin
			run_cycle(t);
			cnt++;
		end
		if (rdy !== 1'b0)
		begin
			note_failure($sformatf("%s: rdy stayed high, program never started", t_name[t]));
			return;
		end
		cnt = 0;
		while (rdy !== 1'b1 && cnt < TIMEOUT)
		begin
			run_cycle(t);
			cnt++;
		end
		if (rdy !== 1'b1)
		begin
			note_failure($sformatf("%s: no halt within %0d cycles", t_name[t], TIMEOUT));
			return;
		end
		repeat (3) run_cycle(t);			// late strobes count as extra
		check_rdy(t_name[t], 1'b1, rdy);
		if (n_seen < NEXP[t])
			note_failure($sformatf("%s: only %0d of %0d port writes seen", t_name[t],
				n_seen, NEXP[t]));
	endtask

	initial
	begin
		int wait_cnt;
		int t;
		rst_n      = 1'b0;
		apu_halt   = 1'b0;
		code_wen   = 1'b0;
		code_waddr = '0;
		code_wdata = '0;
		pins       = '0;
		n_checks   = 0;
		value_errs = 0;
		other_errs = 0;
		void'($urandom(32'h8b2e));
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// core comes up stopped on the halt word
		wait_cnt = 0;
		while (rdy !== 1'b1 && wait_cnt < TIMEOUT)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		if (rdy !== 1'b1)
			note_failure("reset: rdy never rose after reset");
		repeat (8)
		begin
			@(negedge clk);
			if (border_we || covox_we)
				note_failure("reset: port strobe seen while idle after reset");
		end
		check_rdy("reset", 1'b1, rdy);

		for (t = 0; t < N_TESTS; t++)
		begin
			load_program(t);
			run_program(t);
		end

		$display("%0d checks, %0d wrong values, %0d other failures", n_checks, value_errs,
			other_errs);
		if (value_errs + other_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* list.f */
src/apu_pkg.sv
src/apu_fetch.sv
src/apu_gpr.sv
src/apu_exec.sv
src/apu_top.sv
sim/apu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= apu_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Errors found

SRCS := $(shell cat $(FILELIST))
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a crashed simulation also counts as failed
run: compile
	@./$(EXE) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
